// ==== sources.f ====
+incdir+hw
hw/obj_pkg.sv
hw/obj_table_dma.sv
hw/obj_scan.sv
hw/obj_subsystem.sv
verification/tb_clock.sv
verification/obj_subsystem_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the object subsystem testbench with Verilator and runs it

set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_build
LOG_FILE=sim.log

verilator --binary --timing --assert -f sources.f \
    --top-module obj_subsystem_tb -Mdir "$BUILD_DIR" -o obj_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

"./$BUILD_DIR/obj_sim" > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST PASS$" "$LOG_FILE"; then
    exit 0
fi
exit 1

// ==== verification/obj_subsystem_tb.sv ====
// object subsystem testbench: VRAM model, credit sink, directed tests, watchdog and summary
`timescale 1ns/1ps

`include "obj_params.svh"

module obj_subsystem_tb;

    import obj_pkg::*;

    localparam int  TEST_COUNT   = 6;
    localparam int  BANK_WORDS   = `OBJ_ENTRIES * `OBJ_WORDS;
    // well above the longest gap between two objects while credits flow
    localparam int  QUIET_CYCLES = 40;
    localparam time WATCHDOG_NS  = TEST_COUNT * 2_000_000;

    logic        clk;
    logic        rst = 1'b1;
    logic        frame_start = 1'b0;
    logic [15:0] vram_base = '0;
    logic [15:0] vram_data = '0;
    logic        vram_ok = 1'b0;
    logic        obj_credit = 1'b0;
    logic        dma_clr;
    logic        vram_cs;
    logic [16:0] vram_addr;
    logic        obj_valid;
    logic [15:0] obj_x;
    logic [15:0] obj_y;
    logic [15:0] obj_code;
    obj_attr_u   obj_attr;

    // whole 17-bit VRAM word space
    logic [15:0] vram_mem [0:131071];
    // table last written to VRAM, entry order
    logic [15:0] tx [$];
    logic [15:0] ty [$];
    logic [15:0] tcode [$];
    logic [15:0] tattr [$];
    // received objects {x, y, code, attr} and accepted VRAM addresses
    logic [63:0] rx_q [$];
    logic [16:0] addr_q [$];

    int   sent_count = 0;
    int   returned_count = 0;
    int   clr_count = 0;
    int   clr_long_count = 0;
    int   error_count = 0;
    int   check_count = 0;
    int   ok_gap = 0;
    int   credit_wait = 0;
    logic withhold = 1'b0;
    logic clr_prev = 1'b0;

    tb_clock #(.PERIOD(100)) u_tb_clock (.clk(clk));

    obj_subsystem u_obj_subsystem (
        .clk         (clk),
        .rst         (rst),
        .frame_start (frame_start),
        .dma_clr     (dma_clr),
        .vram_base   (vram_base),
        .vram_addr   (vram_addr),
        .vram_data   (vram_data),
        .vram_ok     (vram_ok),
        .vram_cs     (vram_cs),
        .obj_valid   (obj_valid),
        .obj_x       (obj_x),
        .obj_y       (obj_y),
        .obj_code    (obj_code),
        .obj_attr    (obj_attr),
        .obj_credit  (obj_credit)
    );

    // VRAM answers a select with ok and the addressed word, 1 to 3 cycles apart
    always @(negedge clk) begin
        vram_ok = 1'b0;
        if (!vram_cs) begin
            ok_gap = 0;
        end else if (ok_gap == 0) begin
            vram_ok   = 1'b1;
            vram_data = vram_mem[vram_addr];
            ok_gap    = $urandom_range(3, 1);
        end else begin
            ok_gap = ok_gap - 1;
        end
    end

    // renderer side, one credit pulse per object after a random delay
    always @(negedge clk) begin
        obj_credit = 1'b0;
        if (!withhold && sent_count > returned_count) begin
            if (credit_wait == 0) begin
                obj_credit     = 1'b1;
                returned_count = returned_count + 1;
                credit_wait    = $urandom_range(3, 0);
            end else begin
                credit_wait = credit_wait - 1;
            end
        end
    end

    // object capture into the sink FIFO
    always @(posedge clk) begin
        if (!rst && obj_valid) begin
            rx_q.push_back({obj_x, obj_y, obj_code, obj_attr});
            sent_count = sent_count + 1;
        end
    end

    // clear strobe width and VRAM address order
    always @(posedge clk) begin
        if (!rst) begin
            if (dma_clr) begin
                clr_count = clr_count + 1;
            end
            if (dma_clr && clr_prev) begin
                clr_long_count = clr_long_count + 1;
                $display("ERROR @%0t: dma_clr high for two cycles in a row", $time);
            end
            clr_prev = dma_clr;
            // a repeated ok on the same word is the one the DMA skips
            if (vram_cs && vram_ok && (addr_q.size() == 0 || addr_q[$] != vram_addr)) begin
                addr_q.push_back(vram_addr);
            end
        end
    end

    // random table in VRAM at a 256-word page, end marker entry optional
    task automatic write_table(input int page, input int count, input bit marker);
        obj_attr_u   attr;
        logic [16:0] wa;
        tx.delete();
        ty.delete();
        tcode.delete();
        tattr.delete();
        for (int i = 0; i < count; i++) begin
            // y_size below 15 keeps the high byte off the marker value
            attr.field.y_size  = 4'($urandom_range(14, 0));
            attr.field.x_size  = 4'($urandom);
            attr.field.pad     = 1'($urandom);
            attr.field.y_flip  = 1'($urandom);
            attr.field.x_flip  = 1'($urandom);
            attr.field.palette = 5'($urandom);
            tx.push_back(16'($urandom));
            ty.push_back(16'($urandom));
            tcode.push_back(16'($urandom));
            tattr.push_back(attr);
            wa = 17'(page * 256 + 4 * i);
            vram_mem[wa]         = tx[i];
            vram_mem[wa + 17'd1] = ty[i];
            vram_mem[wa + 17'd2] = tcode[i];
            vram_mem[wa + 17'd3] = tattr[i];
        end
        if (marker) begin
            wa = 17'(page * 256 + 4 * count + 3);
            vram_mem[wa] = {`OBJ_END_MARK, 8'($urandom)};
        end
    endtask

    // caller sits on a falling edge
    task automatic pulse_frame();
        frame_start = 1'b1;
        @(negedge clk);
        frame_start = 1'b0;
    endtask

    task automatic wait_copy();
        while (vram_cs) begin
            @(negedge clk);
        end
        // zero fill after a marker covers at most one bank
        repeat (BANK_WORDS + 4) @(negedge clk);
    endtask

    // no objects and no credits outstanding for a while
    task automatic wait_quiet();
        int idle;
        idle = 0;
        while (idle < QUIET_CYCLES) begin
            @(negedge clk);
            if (obj_valid || sent_count != returned_count) begin
                idle = 0;
            end else begin
                idle = idle + 1;
            end
        end
    endtask

    task automatic wait_objects(input int target, input int limit);
        int cycles;
        cycles = 0;
        while (rx_q.size() < target && cycles < limit) begin
            @(negedge clk);
            cycles = cycles + 1;
        end
    endtask

    // received objects from mark on against the written table
    task automatic compare_objects(input int mark, input int count, input string tag);
        obj_attr_u   got_attr;
        obj_attr_u   exp_attr;
        logic [63:0] got;
        int          n;
        n = rx_q.size() - mark;
        check_count = check_count + 1;
        if (n != count) begin
            error_count = error_count + 1;
            $display("ERROR @%0t: %s emitted %0d objects, expected %0d", $time, tag, n, count);
        end
        for (int i = 0; i < count && i < n; i++) begin
            got      = rx_q[mark + i];
            got_attr = got[15:0];
            exp_attr = tattr[i];
            check_count = check_count + 1;
            if (got[63:16] != {tx[i], ty[i], tcode[i]}) begin
                error_count = error_count + 1;
                $display("ERROR @%0t: %s object %0d x/y/code %h expected %h", $time, tag, i,
                         got[63:16], {tx[i], ty[i], tcode[i]});
            end
            // pad bit has no meaning, named fields only
            check_count = check_count + 1;
            if (got_attr.field.y_size != exp_attr.field.y_size ||
                got_attr.field.x_size != exp_attr.field.x_size ||
                got_attr.field.y_flip != exp_attr.field.y_flip ||
                got_attr.field.x_flip != exp_attr.field.x_flip ||
                got_attr.field.palette != exp_attr.field.palette) begin
                error_count = error_count + 1;
                $display("ERROR @%0t: %s object %0d attribute %h expected fields of %h",
                         $time, tag, i, got_attr, exp_attr);
            end
        end
    endtask

    task automatic copy_table();
        pulse_frame();
        wait_copy();
        wait_quiet();
    endtask

    // bank copied last goes on display, its objects come out in order
    task automatic show_table(input int count, input string tag);
        int mark;
        int clr_before;
        mark       = rx_q.size();
        clr_before = clr_count;
        pulse_frame();
        wait_objects(mark + count, count * 20 + 100);
        wait_copy();
        wait_quiet();
        compare_objects(mark, count, tag);
        check_count = check_count + 1;
        if (clr_count != clr_before + 1) begin
            error_count = error_count + 1;
            $display("ERROR @%0t: %s saw %0d dma_clr pulses, expected 1", $time, tag,
                     clr_count - clr_before);
        end
    endtask

    task automatic test_first_frame();
        int mark;
        write_table(0, 3, 1'b1);
        mark = rx_q.size();
        pulse_frame();
        repeat (8) @(negedge clk);
        if (!vram_cs) begin
            error_count = error_count + 1;
            $display("ERROR @%0t: copy ended before the repeated frame start", $time);
        end
        // DMA busy, this start is not accepted
        pulse_frame();
        wait_copy();
        wait_quiet();
        check_count = check_count + 1;
        if (rx_q.size() != mark) begin
            error_count = error_count + 1;
            $display("ERROR @%0t: first frame emitted %0d objects, expected 0", $time,
                     rx_q.size() - mark);
        end
        check_count = check_count + 1;
        if (clr_count != 1) begin
            error_count = error_count + 1;
            $display("ERROR @%0t: dma_clr pulsed %0d times, expected 1", $time, clr_count);
        end
    endtask

    task automatic test_end_marker();
        write_table(0, 5, 1'b1);
        copy_table();
        show_table(5, "end marker table");
    endtask

    task automatic test_full_table();
        write_table(0, `OBJ_ENTRIES, 1'b0);
        copy_table();
        show_table(`OBJ_ENTRIES, "full table");
    endtask

    // both banks hold the full table at this point
    task automatic test_short_after_long();
        write_table(0, 2, 1'b1);
        copy_table();
        show_table(2, "short table");
    endtask

    task automatic test_credit_hold();
        int mark;
        write_table(0, 10, 1'b1);
        copy_table();
        mark     = rx_q.size();
        withhold = 1'b1;
        pulse_frame();
        wait_objects(mark + `OBJ_CREDITS, 400);
        // scanner has to stay stalled without credits
        repeat (QUIET_CYCLES * 4) @(negedge clk);
        check_count = check_count + 1;
        if (rx_q.size() - mark != `OBJ_CREDITS) begin
            error_count = error_count + 1;
            $display("ERROR @%0t: %0d objects without credit return, expected %0d", $time,
                     rx_q.size() - mark, `OBJ_CREDITS);
        end
        withhold = 1'b0;
        wait_objects(mark + 10, 400);
        wait_copy();
        wait_quiet();
        compare_objects(mark, 10, "credit hold table");
    endtask

    task automatic test_base_change();
        int          amark;
        int          n;
        logic [16:0] exp_addr;
        vram_base = 16'd8;
        write_table(8, 3, 1'b1);
        amark = addr_q.size();
        pulse_frame();
        wait_copy();
        // three entries plus the marker attribute
        n = 4 * 3 + 1;
        check_count = check_count + 1;
        if (addr_q.size() - amark != n) begin
            error_count = error_count + 1;
            $display("ERROR @%0t: copy read %0d VRAM words, expected %0d", $time,
                     addr_q.size() - amark, n);
        end
        for (int i = 0; i < n && amark + i < addr_q.size(); i++) begin
            exp_addr = 17'(8 * 256 + 4 * (i / 4) + 3 - (i % 4));
            check_count = check_count + 1;
            if (addr_q[amark + i] != exp_addr) begin
                error_count = error_count + 1;
                $display("ERROR @%0t: VRAM read %0d at %h expected %h", $time, i,
                         addr_q[amark + i], exp_addr);
            end
        end
        wait_quiet();
        show_table(3, "new base table");
    endtask

    initial begin
        void'($urandom(32'h76d3ed18));
        for (int a = 0; a < 131072; a++) begin
            vram_mem[17'(a)] = 16'(a ^ (a >> 5) ^ (a >> 16));
        end
        repeat (4) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        test_first_frame();
        test_end_marker();
        test_full_table();
        test_short_after_long();
        test_credit_hold();
        test_base_change();
        error_count = error_count + clr_long_count;
        $display("summary: %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // 2 ms per test
    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the tests finished");
        $display("TEST FAIL");
        $finish;
    end

endmodule

// ==== verification/tb_clock.sv ====
// testbench clock source
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD = 100
) (
    output logic clk
);

    // free running, starts low
    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2);
            clk = ~clk;
        end
    end

endmodule

// ==== hw/obj_subsystem.sv ====
// object table front end top: table DMA feeding the object scanner
`timescale 1ns/1ps

module obj_subsystem (
    input  logic               clk,
    input  logic               rst,
    input  logic               frame_start,
    output logic               dma_clr,
    input  logic [15:0]        vram_base,
    output logic [16:0]        vram_addr,
    input  logic [15:0]        vram_data,
    input  logic               vram_ok,
    output logic               vram_cs,
    output logic               obj_valid,
    output logic [15:0]        obj_x,
    output logic [15:0]        obj_y,
    output logic [15:0]        obj_code,
    output obj_pkg::obj_attr_u obj_attr,
    input  logic               obj_credit
);

    import obj_pkg::*;

    // scanner read port into the displayed bank
    logic [9:0]  table_addr;
    logic [15:0] table_data;
    // valid entries of the displayed bank
    obj_count_t  disp_count;

    obj_table_dma u_obj_table_dma (
        .clk         (clk),
        .rst         (rst),
        .frame_start (frame_start),
        .vram_base   (vram_base),
        .vram_data   (vram_data),
        .vram_ok     (vram_ok),
        .table_addr  (table_addr),
        .dma_clr     (dma_clr),
        .vram_cs     (vram_cs),
        .vram_addr   (vram_addr),
        .table_data  (table_data),
        // bank select stays inside the DMA read port
        .disp_bank   (),
        .disp_count  (disp_count)
    );

    obj_scan u_obj_scan (
        .clk         (clk),
        .rst         (rst),
        .frame_start (frame_start),
        .disp_count  (disp_count),
        .table_data  (table_data),
        .obj_credit  (obj_credit),
        .table_addr  (table_addr),
        .obj_valid   (obj_valid),
        .obj_x       (obj_x),
        .obj_y       (obj_y),
        .obj_code    (obj_code),
        .obj_attr    (obj_attr)
    );

endmodule

// ==== hw/obj_scan.sv ====
// object scanner walking the displayed bank and handing out objects against renderer credits
`timescale 1ns/1ps

`include "obj_params.svh"

module obj_scan (
    input  logic                clk,
    input  logic                rst,
    input  logic                frame_start,
    input  obj_pkg::obj_count_t disp_count,
    input  logic [15:0]         table_data,
    input  logic                obj_credit,
    output logic [9:0]          table_addr,
    output logic                obj_valid,
    output logic [15:0]         obj_x,
    output logic [15:0]         obj_y,
    output logic [15:0]         obj_code,
    output obj_pkg::obj_attr_u  obj_attr
);

    import obj_pkg::*;

    localparam int CRED_W = $clog2(`OBJ_CREDITS + 1);
    localparam logic [2:0] LAST_STEP = 3'(`OBJ_WORDS);

    typedef enum logic [1:0] {
        SC_IDLE,
        SC_FETCH,
        SC_EMIT
    } scan_state_t;

    scan_state_t       state;
    obj_count_t        idx;
    logic [2:0]        step;
    logic [CRED_W-1:0] credit_cnt;
    obj_attr_u         attr_in;
    obj_attr_u         attr_clean;

    // step 0..3 issue words 0..3
    // step 4 only collects the last read
    assign table_addr = {idx[7:0], step[1:0]};

    // attribute through the field view with the unused bit cleared
    always_comb begin
        attr_in              = table_data;
        attr_clean           = attr_in;
        attr_clean.field.pad = 1'b0;
    end

    // data lags the address by a cycle
    // so step s picks up word s-1
    always_ff @(posedge clk) begin
        if (state == SC_FETCH) begin
            case (step)
                3'd1: obj_x <= table_data;
                3'd2: obj_y <= table_data;
                3'd3: obj_code <= table_data;
                3'd4: obj_attr <= attr_clean;
                default: begin
                end
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= SC_IDLE;
            idx        <= '0;
            step       <= '0;
            obj_valid  <= 1'b0;
            credit_cnt <= CRED_W'(`OBJ_CREDITS);
        end else begin
            obj_valid <= 1'b0;

            // returned credit and a spent one in the same cycle cancel
            case ({obj_credit, obj_valid})
                2'b10: credit_cnt <= credit_cnt + 1'b1;
                2'b01: credit_cnt <= credit_cnt - 1'b1;
                default: begin
                end
            endcase

            if (frame_start) begin
                // restart on the new bank
                // a pending object is dropped
                state <= SC_FETCH;
                idx   <= '0;
                step  <= '0;
            end else begin
                case (state)
                    SC_IDLE: begin
                        step <= '0;
                    end
                    SC_FETCH: begin
                        if (step == 3'd0 && idx == disp_count) begin
                            // bank done until the next frame
                            state <= SC_IDLE;
                        end else if (step == LAST_STEP) begin
                            step  <= '0;
                            state <= SC_EMIT;
                        end else begin
                            step <= step + 3'd1;
                        end
                    end
                    SC_EMIT: begin
                        // entry held while no credit is left
                        if (credit_cnt != '0) begin
                            obj_valid <= 1'b1;
                            idx       <= idx + 9'd1;
                            state     <= SC_FETCH;
                        end
                    end
                    default: begin
                        state <= SC_IDLE;
                    end
                endcase
            end
        end
    end

    // renderer must not hand back more than it was given
    a_credit_max: assert property (
        @(posedge clk) disable iff (rst)
        credit_cnt <= CRED_W'(`OBJ_CREDITS)
    ) else $error("credit count above renderer FIFO depth");

    // decision taken a cycle before the pulse
    // spend lands with the pulse itself
    a_valid_has_credit: assert property (
        @(posedge clk) disable iff (rst)
        obj_valid |-> (credit_cnt != '0)
    ) else $error("object sent without a credit");

endmodule

// ==== hw/obj_table_dma.sv ====
// object table DMA: VRAM copy with end marker stop, zero fill and two-bank table RAM
`timescale 1ns/1ps

`include "obj_params.svh"

module obj_table_dma (
    input  logic                clk,
    input  logic                rst,
    input  logic                frame_start,
    input  logic [15:0]         vram_base,
    input  logic [15:0]         vram_data,
    input  logic                vram_ok,
    input  logic [9:0]          table_addr,
    output logic                dma_clr,
    output logic                vram_cs,
    output logic [16:0]         vram_addr,
    output logic [15:0]         table_data,
    output logic                disp_bank,
    output obj_pkg::obj_count_t disp_count
);

    import obj_pkg::*;

    // both banks back to back, bank bit on top
    localparam int RAM_DEPTH = 2 * `OBJ_ENTRIES * `OBJ_WORDS;
    localparam logic [9:0] LAST_WORD = 10'(`OBJ_ENTRIES * `OBJ_WORDS - 1);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_COPY,
        ST_FILL
    } dma_state_t;

    dma_state_t  state;
    logic [16:0] vram_cnt;
    logic [9:0]  word_cnt;
    logic        wait_cycle;
    obj_count_t  entry_cnt;
    obj_attr_u   vram_attr;
    logic        word_accept;
    logic        end_seen;
    logic        ram_we;
    logic [15:0] ram_wdata;
    logic [10:0] ram_waddr;

    logic [15:0] table_ram [0:RAM_DEPTH-1];

    // counters run in natural order
    // low two bits flipped so the attribute word (3) goes out first
    assign vram_addr = {vram_cnt[16:2], ~vram_cnt[1:0]};

    assign vram_attr = vram_data;

    // one word per ok, skipping the cycle right after an accepted word
    assign word_accept = (state == ST_COPY) && vram_ok && !wait_cycle;

    // marker only counts on the first word of an entry, the attribute
    assign end_seen = word_accept && (word_cnt[1:0] == 2'b00) &&
                      (vram_attr.raw.end_mark == `OBJ_END_MARK);

    // write side always targets the bank not on display
    assign ram_waddr = {~disp_bank, word_cnt[9:2], ~word_cnt[1:0]};

    always_comb begin
        ram_we    = 1'b0;
        ram_wdata = vram_data;
        if (state == ST_FILL) begin
            // rest of the bank after the marker
            ram_we    = 1'b1;
            ram_wdata = '0;
        end else if (word_accept && !end_seen) begin
            ram_we = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (ram_we) begin
            table_ram[ram_waddr] <= ram_wdata;
        end
    end

    // scanner read port, one cycle latency
    always_ff @(posedge clk) begin
        table_data <= table_ram[{disp_bank, table_addr}];
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= ST_IDLE;
            vram_cs    <= 1'b0;
            vram_cnt   <= '0;
            word_cnt   <= '0;
            wait_cycle <= 1'b1;
            entry_cnt  <= '0;
            disp_bank  <= 1'b0;
            disp_count <= '0;
            dma_clr    <= 1'b0;
        end else begin
            dma_clr <= 1'b0;
            case (state)
                ST_IDLE: begin
                    // base register counts in 256-word pages
                    vram_cnt   <= {vram_base[8:0], 8'd0};
                    word_cnt   <= '0;
                    wait_cycle <= 1'b1;
                    if (frame_start) begin
                        // finished bank goes on display with its count
                        disp_bank  <= ~disp_bank;
                        disp_count <= entry_cnt;
                        entry_cnt  <= '0;
                        vram_cs    <= 1'b1;
                        dma_clr    <= 1'b1;
                        state      <= ST_COPY;
                    end
                end
                ST_COPY: begin
                    wait_cycle <= 1'b0;
                    if (end_seen) begin
                        // marker slot itself is zeroed by the fill
                        vram_cs <= 1'b0;
                        state   <= ST_FILL;
                    end else if (word_accept) begin
                        vram_cnt   <= vram_cnt + 17'd1;
                        word_cnt   <= word_cnt + 10'd1;
                        wait_cycle <= 1'b1;
                        // word 0 is the last one of an entry to arrive
                        if (word_cnt[1:0] == 2'b11) begin
                            entry_cnt <= entry_cnt + 9'd1;
                        end
                        if (word_cnt == LAST_WORD) begin
                            vram_cs <= 1'b0;
                            state   <= ST_IDLE;
                        end
                    end
                end
                ST_FILL: begin
                    word_cnt <= word_cnt + 10'd1;
                    if (word_cnt == LAST_WORD) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    vram_cs <= 1'b0;
                    state   <= ST_IDLE;
                end
            endcase
        end
    end

    // chip select only lives inside a copy
    a_cs_not_idle: assert property (
        @(posedge clk) disable iff (rst)
        (state == ST_IDLE) |-> !vram_cs
    ) else $error("vram_cs high while the DMA is idle");

    // clear strobe is a single cycle, never stretched by a second start
    a_clr_one_cycle: assert property (
        @(posedge clk) disable iff (rst)
        dma_clr |=> !dma_clr
    ) else $error("dma_clr held longer than one cycle");

endmodule

// ==== hw/obj_pkg.sv ====
// object table types: attribute word union and valid entry count
package obj_pkg;

    // raw view, only the high byte matters for the end marker
    typedef struct packed {
        logic [7:0] end_mark;
        logic [7:0] low;
    } obj_attr_raw_t;

    // field view as the renderer sees it
    // bit 7 has no function
    typedef struct packed {
        logic [3:0] y_size;
        logic [3:0] x_size;
        logic       pad;
        logic       y_flip;
        logic       x_flip;
        logic [4:0] palette;
    } obj_attr_fields_t;

    // same 16-bit attribute word, two decodings
    typedef union packed {
        obj_attr_raw_t    raw;
        obj_attr_fields_t field;
    } obj_attr_u;

    // valid entries in a bank, 0 up to a full bank of 256
    typedef logic [8:0] obj_count_t;

endpackage

// ==== hw/obj_params.svh ====
// object table geometry, end marker and renderer credit depth macros
`ifndef OBJ_PARAMS_SVH
`define OBJ_PARAMS_SVH

// entries in one bank of the object table
`define OBJ_ENTRIES 256

// words per entry, x / y / code / attribute
`define OBJ_WORDS 4

// renderer object FIFO depth
// also the scanner's credit count out of reset
`define OBJ_CREDITS 4

// attribute high byte that terminates a table
`define OBJ_END_MARK 8'hFF

`endif
